// ==== Makefile ====
TOP = issue_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^sim passed$$" sim.log

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)
	verilator --lint-only +incdir+source source/riscv_pkg.sv source/pipeline_pkg.sv \
		source/register_file.sv source/operand_bypass.sv source/hazard_detect.sv \
		source/issue_stage.sv source/issue_top.sv --top-module issue_top

clean:
	rm -rf obj_dir sim.log

// ==== source/hazard_detect.sv ====
`include "issue_settings.svh"

module hazard_detect
    import riscv_pkg::*;
(
    input logic clock,
    input logic reset,
    input logic d_valid [`ISSUE_WIDTH],
    input reg_addr_t d_raddr1 [`ISSUE_WIDTH],
    input reg_addr_t d_raddr2 [`ISSUE_WIDTH],
    input logic d_rden1 [`ISSUE_WIDTH],
    input logic d_rden2 [`ISSUE_WIDTH],
    input logic d_frden1 [`ISSUE_WIDTH],
    input logic d_frden2 [`ISSUE_WIDTH],
    input logic e_valid [`ISSUE_WIDTH],
    input logic e_load [`ISSUE_WIDTH],
    input logic e_fload [`ISSUE_WIDTH],
    input reg_addr_t e_waddr [`ISSUE_WIDTH],
    input logic stall_in,
    input logic flush,
    output logic issue_stall,
    output logic hazard
);

    function automatic logic reads_target(
        input logic en1,
        input reg_addr_t addr1,
        input logic en2,
        input reg_addr_t addr2,
        input reg_addr_t target
    );
        return (en1 && addr1 == target) || (en2 && addr2 == target);
    endfunction

    // Every decode slot against every execute slot.
    always_comb begin
        hazard = 1'b0;
        for (int d = 0; d < `ISSUE_WIDTH; d++) begin
            for (int e = 0; e < `ISSUE_WIDTH; e++) begin
                if (d_valid[d] && e_valid[e]) begin
                    if (e_load[e] && e_waddr[e] != zero_addr &&
                        reads_target(d_rden1[d], d_raddr1[d], d_rden2[d], d_raddr2[d],
                                     e_waddr[e])) begin
                        hazard = 1'b1; // Integer load-use.
                    end
                    if (e_fload[e] &&
                        reads_target(d_frden1[d], d_raddr1[d], d_frden2[d], d_raddr2[d],
                                     e_waddr[e])) begin
                        hazard = 1'b1; // FP load-use.
                    end
                end
            end
        end
    end

    assign issue_stall = (hazard || stall_in) && !flush;

    a_flush_releases: assert property (@(posedge clock) disable iff (!reset)
        flush |-> !issue_stall)
        else $error("hazard_detect: issue_stall raised during flush");

endmodule

// ==== source/issue_settings.svh ====
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// Integer and floating-point datapath widths.
`define XLEN 32
`define FLEN 64

`define REG_COUNT 32 // Entries in each register file.

// Instructions offered by the decoder per cycle.
`define ISSUE_WIDTH 2

`endif

// ==== source/issue_stage.sv ====
`include "issue_settings.svh"

module issue_stage
    import riscv_pkg::*;
    import pipeline_pkg::*;
(
    input logic clock,
    input logic reset,
    input logic d_valid [`ISSUE_WIDTH],
    input xword_t d_pc [`ISSUE_WIDTH],
    input reg_addr_t d_raddr1 [`ISSUE_WIDTH],
    input reg_addr_t d_raddr2 [`ISSUE_WIDTH],
    input reg_addr_t d_waddr [`ISSUE_WIDTH],
    input logic d_rden1 [`ISSUE_WIDTH],
    input logic d_rden2 [`ISSUE_WIDTH],
    input logic d_frden1 [`ISSUE_WIDTH],
    input logic d_frden2 [`ISSUE_WIDTH],
    input logic d_wren [`ISSUE_WIDTH],
    input logic d_fwren [`ISSUE_WIDTH],
    input logic d_load [`ISSUE_WIDTH],
    input logic d_fload [`ISSUE_WIDTH],
    input logic d_fp_op [`ISSUE_WIDTH],
    input xword_t rdata1 [`ISSUE_WIDTH],
    input xword_t rdata2 [`ISSUE_WIDTH],
    input fword_t frdata1 [`ISSUE_WIDTH],
    input fword_t frdata2 [`ISSUE_WIDTH],
    input bypass_source_t rsource [2*`ISSUE_WIDTH],
    input logic hazard,
    input logic stall_in,
    input logic flush,
    input fs_state_t fs,
    output logic q_valid [`ISSUE_WIDTH],
    output xword_t q_pc [`ISSUE_WIDTH],
    output reg_addr_t q_waddr [`ISSUE_WIDTH],
    output logic q_wren [`ISSUE_WIDTH],
    output logic q_fwren [`ISSUE_WIDTH],
    output logic q_load [`ISSUE_WIDTH],
    output logic q_fload [`ISSUE_WIDTH],
    output logic q_fp_op [`ISSUE_WIDTH],
    output xword_t q_rdata1 [`ISSUE_WIDTH],
    output xword_t q_rdata2 [`ISSUE_WIDTH],
    output fword_t q_frdata1 [`ISSUE_WIDTH],
    output fword_t q_frdata2 [`ISSUE_WIDTH]
);

    logic fp_on;
    logic accept;
    logic take [`ISSUE_WIDTH];

    assign fp_on = (fs != fs_off);
    assign accept = !stall_in && !hazard && !flush; // Pair moves on.

    always_comb begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            take[i] = d_valid[i] && !hazard;
        end
    end

    // Control flags, a bubble under hazard.
    always_ff @(posedge clock) begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            if (!reset || flush) begin
                q_valid[i] <= 1'b0;
                q_wren[i] <= 1'b0;
                q_fwren[i] <= 1'b0;
                q_load[i] <= 1'b0;
                q_fload[i] <= 1'b0;
                q_fp_op[i] <= 1'b0;
            end else if (!stall_in) begin
                q_valid[i] <= take[i];
                q_wren[i] <= take[i] && d_wren[i];
                q_fwren[i] <= take[i] && fp_on && d_fwren[i];
                q_load[i] <= take[i] && d_load[i];
                q_fload[i] <= take[i] && fp_on && d_fload[i];
                q_fp_op[i] <= take[i] && fp_on && d_fp_op[i];
            end
        end
    end

    // Payload only moves with an accepted pair.
    always_ff @(posedge clock) begin
        if (accept) begin
            for (int i = 0; i < `ISSUE_WIDTH; i++) begin
                q_pc[i] <= d_pc[i];
                q_waddr[i] <= d_waddr[i];
                q_rdata1[i] <= d_rden1[i] ? rdata1[i] : '0;
                q_rdata2[i] <= d_rden2[i] ? rdata2[i] : '0;
                // FPU off reads as zero.
                q_frdata1[i] <= (fp_on && d_frden1[i]) ? frdata1[i] : '0;
                q_frdata2[i] <= (fp_on && d_frden2[i]) ? frdata2[i] : '0;
            end
        end
    end

    for (genvar s = 0; s < `ISSUE_WIDTH; s++) begin : g_check
        a_flush_bubble: assert property (@(posedge clock) disable iff (!reset)
            flush |=> !q_valid[s])
            else $error("issue_stage: slot %0d valid after flush", s);

        // Integer x0 never arrives through a bypass path.
        a_zero_from_file: assert property (@(posedge clock) disable iff (!reset)
            accept && d_valid[s] |->
                (d_raddr1[s] != zero_addr || rsource[2*s] == from_file) &&
                (d_raddr2[s] != zero_addr || rsource[2*s+1] == from_file))
            else $error("issue_stage: slot %0d took x0 from a bypass", s);
    end

endmodule

// ==== source/issue_top.sv ====
`include "issue_settings.svh"

module issue_top
    import riscv_pkg::*;
    import pipeline_pkg::*;
(
    input logic clock,
    input logic reset,
    input logic d_valid [`ISSUE_WIDTH],
    input xword_t d_pc [`ISSUE_WIDTH],
    input reg_addr_t d_raddr1 [`ISSUE_WIDTH],
    input reg_addr_t d_raddr2 [`ISSUE_WIDTH],
    input reg_addr_t d_waddr [`ISSUE_WIDTH],
    input logic d_rden1 [`ISSUE_WIDTH],
    input logic d_rden2 [`ISSUE_WIDTH],
    input logic d_frden1 [`ISSUE_WIDTH],
    input logic d_frden2 [`ISSUE_WIDTH],
    input logic d_wren [`ISSUE_WIDTH],
    input logic d_fwren [`ISSUE_WIDTH],
    input logic d_load [`ISSUE_WIDTH],
    input logic d_fload [`ISSUE_WIDTH],
    input logic d_fp_op [`ISSUE_WIDTH],
    input logic e_valid [`ISSUE_WIDTH],
    input logic e_load [`ISSUE_WIDTH],
    input logic e_fload [`ISSUE_WIDTH],
    input logic e_wren [`ISSUE_WIDTH],
    input logic e_fwren [`ISSUE_WIDTH],
    input reg_addr_t e_waddr [`ISSUE_WIDTH],
    input xword_t e_result [`ISSUE_WIDTH],
    input fword_t e_fresult [`ISSUE_WIDTH],
    input logic w_wren [`ISSUE_WIDTH],
    input logic w_fwren [`ISSUE_WIDTH],
    input reg_addr_t w_waddr [`ISSUE_WIDTH],
    input xword_t w_data [`ISSUE_WIDTH],
    input fword_t w_fdata [`ISSUE_WIDTH],
    input logic stall_in,
    input logic flush,
    input fs_state_t fs,
    output logic issue_stall,
    output logic q_valid [`ISSUE_WIDTH],
    output xword_t q_pc [`ISSUE_WIDTH],
    output reg_addr_t q_waddr [`ISSUE_WIDTH],
    output logic q_wren [`ISSUE_WIDTH],
    output logic q_fwren [`ISSUE_WIDTH],
    output logic q_load [`ISSUE_WIDTH],
    output logic q_fload [`ISSUE_WIDTH],
    output logic q_fp_op [`ISSUE_WIDTH],
    output xword_t q_rdata1 [`ISSUE_WIDTH],
    output xword_t q_rdata2 [`ISSUE_WIDTH],
    output fword_t q_frdata1 [`ISSUE_WIDTH],
    output fword_t q_frdata2 [`ISSUE_WIDTH]
);

    // Operand n belongs to slot n/2; even n is source 1.
    reg_addr_t read_addr [2*`ISSUE_WIDTH];
    xword_t x_file [2*`ISSUE_WIDTH];
    fword_t f_file [2*`ISSUE_WIDTH];
    xword_t x_opnd [2*`ISSUE_WIDTH];
    fword_t f_opnd [2*`ISSUE_WIDTH];
    bypass_source_t rsource [2*`ISSUE_WIDTH];

    xword_t rdata1 [`ISSUE_WIDTH];
    xword_t rdata2 [`ISSUE_WIDTH];
    fword_t frdata1 [`ISSUE_WIDTH];
    fword_t frdata2 [`ISSUE_WIDTH];
    logic hazard;

    for (genvar s = 0; s < `ISSUE_WIDTH; s++) begin : g_slot
        assign read_addr[2*s] = d_raddr1[s];
        assign read_addr[2*s+1] = d_raddr2[s];
        assign rdata1[s] = x_opnd[2*s];
        assign rdata2[s] = x_opnd[2*s+1];
        assign frdata1[s] = f_opnd[2*s];
        assign frdata2[s] = f_opnd[2*s+1];
    end

    register_file #(
        .word_t(xword_t),
        .hardwire_zero(1'b1)
    ) x_regs (
        .clock(clock),
        .reset(reset),
        .wren(w_wren),
        .waddr(w_waddr),
        .wdata(w_data),
        .raddr(read_addr),
        .rdata(x_file)
    );

    register_file #(
        .word_t(fword_t),
        .hardwire_zero(1'b0)
    ) f_regs (
        .clock(clock),
        .reset(reset),
        .wren(w_fwren),
        .waddr(w_waddr),
        .wdata(w_fdata),
        .raddr(read_addr),
        .rdata(f_file)
    );

    for (genvar n = 0; n < 2*`ISSUE_WIDTH; n++) begin : g_operand
        operand_bypass #(.word_t(xword_t)) x_bypass (
            .raddr(read_addr[n]),
            .file_data(x_file[n]),
            .e_wren(e_wren),
            .e_waddr(e_waddr),
            .e_data(e_result),
            .w_wren(w_wren),
            .w_waddr(w_waddr),
            .w_data(w_data),
            .zero_reg(1'b1),
            .data(x_opnd[n]),
            .source(rsource[n])
        );

        operand_bypass #(.word_t(fword_t)) f_bypass (
            .raddr(read_addr[n]),
            .file_data(f_file[n]),
            .e_wren(e_fwren),
            .e_waddr(e_waddr),
            .e_data(e_fresult),
            .w_wren(w_fwren),
            .w_waddr(w_waddr),
            .w_data(w_fdata),
            .zero_reg(1'b0),
            .data(f_opnd[n]),
            .source()
        );
    end

    hazard_detect hazards (.*);

    issue_stage stage (.*);

endmodule

// ==== source/operand_bypass.sv ====
`include "issue_settings.svh"

module operand_bypass
    import riscv_pkg::*;
    import pipeline_pkg::*;
#(
    parameter type word_t = xword_t
) (
    input reg_addr_t raddr,
    input word_t file_data,
    input logic e_wren [`ISSUE_WIDTH],
    input reg_addr_t e_waddr [`ISSUE_WIDTH],
    input word_t e_data [`ISSUE_WIDTH],
    input logic w_wren [`ISSUE_WIDTH],
    input reg_addr_t w_waddr [`ISSUE_WIDTH],
    input word_t w_data [`ISSUE_WIDTH],
    input logic zero_reg,
    output word_t data,
    output bypass_source_t source
);

    localparam slot_t older = 1'b0;
    localparam slot_t newer = 1'b1;

    logic e_hit [`ISSUE_WIDTH];
    logic w_hit [`ISSUE_WIDTH];

    always_comb begin
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            e_hit[s] = e_wren[s] && (e_waddr[s] == raddr);
            w_hit[s] = w_wren[s] && (w_waddr[s] == raddr);
        end
    end

    // Youngest result first.
    always_comb begin
        data = file_data;
        source = from_file;
        if (zero_reg && raddr == zero_addr) begin
            data = '0; // Never forwarded.
        end else if (e_hit[newer]) begin
            data = e_data[newer];
            source = from_execute;
        end else if (e_hit[older]) begin
            data = e_data[older];
            source = from_execute;
        end else if (w_hit[newer]) begin
            data = w_data[newer];
            source = from_writeback;
        end else if (w_hit[older]) begin
            data = w_data[older];
            source = from_writeback;
        end
    end

endmodule

// ==== source/pipeline_pkg.sv ====
package pipeline_pkg;

    typedef logic [0:0] slot_t; // Index within an issue pair.

    // Where an operand was taken from.
    typedef enum logic [1:0] {
        from_file = 2'd0,
        from_writeback = 2'd1,
        from_execute = 2'd2
    } bypass_source_t;

endpackage

// ==== source/register_file.sv ====
`include "issue_settings.svh"

module register_file
    import riscv_pkg::*;
#(
    parameter type word_t = xword_t,
    parameter bit hardwire_zero = 1'b1
) (
    input logic clock,
    input logic reset,
    input logic wren [`ISSUE_WIDTH],
    input reg_addr_t waddr [`ISSUE_WIDTH],
    input word_t wdata [`ISSUE_WIDTH],
    input reg_addr_t raddr [2*`ISSUE_WIDTH],
    output word_t rdata [2*`ISSUE_WIDTH]
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Later port is applied last, so slot 1 wins.
            for (int p = 0; p < `ISSUE_WIDTH; p++) begin
                if (wren[p] && !(hardwire_zero && waddr[p] == zero_addr)) begin
                    regs[waddr[p]] <= wdata[p];
                end
            end
        end
    end

    // Old contents on a same-cycle write.
    always_comb begin
        for (int r = 0; r < 2*`ISSUE_WIDTH; r++) begin
            rdata[r] = regs[raddr[r]];
        end
    end

    // Writeback never retires two writes to one register.
    a_single_writer: assert property (@(posedge clock) disable iff (!reset)
        !(wren[0] && wren[1] && waddr[0] == waddr[1]))
        else $error("register_file: both write ports target register %0d", waddr[0]);

endmodule

// ==== source/riscv_pkg.sv ====
package riscv_pkg;

`include "issue_settings.svh"

    typedef logic [`XLEN-1:0] xword_t;
    typedef logic [`FLEN-1:0] fword_t;

    typedef logic [4:0] reg_addr_t; // Five-bit register index.

    // Integer x0 reads as zero.
    localparam reg_addr_t zero_addr = 5'd0;

    // Encoding of the mstatus FS field.
    typedef enum logic [1:0] {
        fs_off = 2'b00,
        fs_initial = 2'b01,
        fs_clean = 2'b10,
        fs_dirty = 2'b11
    } fs_state_t;

endpackage

// ==== tb.f ====
+incdir+source
source/riscv_pkg.sv
source/pipeline_pkg.sv
source/register_file.sv
source/operand_bypass.sv
source/hazard_detect.sv
source/issue_stage.sv
source/issue_top.sv
test/issue_tb.sv

// ==== test/issue_tb.sv ====
`include "issue_settings.svh"

module issue_tb
    import riscv_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int max_cycles = 2000;

    logic clock;
    logic reset;
    logic d_valid [`ISSUE_WIDTH];
    logic d_rden1 [`ISSUE_WIDTH];
    logic d_rden2 [`ISSUE_WIDTH];
    logic d_frden1 [`ISSUE_WIDTH];
    logic d_frden2 [`ISSUE_WIDTH];
    logic d_wren [`ISSUE_WIDTH];
    logic d_fwren [`ISSUE_WIDTH];
    logic d_load [`ISSUE_WIDTH];
    logic d_fload [`ISSUE_WIDTH];
    logic d_fp_op [`ISSUE_WIDTH];
    logic e_valid [`ISSUE_WIDTH];
    logic e_load [`ISSUE_WIDTH];
    logic e_fload [`ISSUE_WIDTH];
    logic e_wren [`ISSUE_WIDTH];
    logic e_fwren [`ISSUE_WIDTH];
    logic w_wren [`ISSUE_WIDTH];
    logic w_fwren [`ISSUE_WIDTH];
    xword_t d_pc [`ISSUE_WIDTH];
    xword_t e_result [`ISSUE_WIDTH];
    xword_t w_data [`ISSUE_WIDTH];
    fword_t e_fresult [`ISSUE_WIDTH];
    fword_t w_fdata [`ISSUE_WIDTH];
    reg_addr_t d_raddr1 [`ISSUE_WIDTH];
    reg_addr_t d_raddr2 [`ISSUE_WIDTH];
    reg_addr_t d_waddr [`ISSUE_WIDTH];
    reg_addr_t e_waddr [`ISSUE_WIDTH];
    reg_addr_t w_waddr [`ISSUE_WIDTH];
    logic stall_in;
    logic flush;
    fs_state_t fs;
    logic issue_stall;
    logic q_valid [`ISSUE_WIDTH];
    logic q_wren [`ISSUE_WIDTH];
    logic q_fwren [`ISSUE_WIDTH];
    logic q_load [`ISSUE_WIDTH];
    logic q_fload [`ISSUE_WIDTH];
    logic q_fp_op [`ISSUE_WIDTH];
    xword_t q_pc [`ISSUE_WIDTH];
    xword_t q_rdata1 [`ISSUE_WIDTH];
    xword_t q_rdata2 [`ISSUE_WIDTH];
    reg_addr_t q_waddr [`ISSUE_WIDTH];
    fword_t q_frdata1 [`ISSUE_WIDTH];
    fword_t q_frdata2 [`ISSUE_WIDTH];

    xword_t x_model [`REG_COUNT]; // Expected register file contents.
    fword_t f_model [`REG_COUNT];
    int cycles = 0;
    logic stall_at_edge = 1'b0; // issue_stall seen at the last rising edge.

    issue_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the tests did not finish within %0d clock cycles.", max_cycles);
            $display("sim failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("sim failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic idle_inputs();
        d_valid = '{default: 1'b0};
        d_pc = '{default: '0};
        d_raddr1 = '{default: '0};
        d_raddr2 = '{default: '0};
        d_waddr = '{default: '0};
        d_rden1 = '{default: 1'b0};
        d_rden2 = '{default: 1'b0};
        d_frden1 = '{default: 1'b0};
        d_frden2 = '{default: 1'b0};
        d_wren = '{default: 1'b0};
        d_fwren = '{default: 1'b0};
        d_load = '{default: 1'b0};
        d_fload = '{default: 1'b0};
        d_fp_op = '{default: 1'b0};
        e_valid = '{default: 1'b0};
        e_load = '{default: 1'b0};
        e_fload = '{default: 1'b0};
        e_wren = '{default: 1'b0};
        e_fwren = '{default: 1'b0};
        e_waddr = '{default: '0};
        e_result = '{default: '0};
        e_fresult = '{default: '0};
        w_wren = '{default: 1'b0};
        w_fwren = '{default: 1'b0};
        w_waddr = '{default: '0};
        w_data = '{default: '0};
        w_fdata = '{default: '0};
        stall_in = 1'b0;
        flush = 1'b0;
        fs = fs_dirty;
    endtask

    // One clock cycle between falling edges.
    task automatic step();
        @(posedge clock);
        stall_at_edge = issue_stall;
        @(negedge clock);
    endtask

    task automatic wait_accept();
        do begin
            step();
        end while (stall_at_edge);
    endtask

    // Slot s reads a1 and a2 from both files.
    task automatic drive_read(input int s, input int a1, input int a2);
        d_valid[s] = 1'b1;
        d_pc[s] = $urandom;
        d_raddr1[s] = reg_addr_t'(a1);
        d_raddr2[s] = reg_addr_t'(a2);
        d_waddr[s] = reg_addr_t'(a1);
        d_rden1[s] = 1'b1;
        d_rden2[s] = 1'b1;
        d_frden1[s] = 1'b1;
        d_frden2[s] = 1'b1;
    endtask

    task automatic check_operands(input int s, input int a1, input int a2);
        check_value($sformatf("q_valid[%0d]", s), 64'(q_valid[s]), 64'h1);
        check_value($sformatf("q_waddr[%0d]", s), 64'(q_waddr[s]), 64'(a1));
        check_value($sformatf("q_rdata1[%0d]", s), 64'(q_rdata1[s]), 64'(x_model[a1]));
        check_value($sformatf("q_rdata2[%0d]", s), 64'(q_rdata2[s]), 64'(x_model[a2]));
        check_value($sformatf("q_frdata1[%0d]", s), q_frdata1[s], f_model[a1]);
        check_value($sformatf("q_frdata2[%0d]", s), q_frdata2[s], f_model[a2]);
    endtask

    task automatic write_pair(input int a0, input int a1);
        w_waddr[0] = reg_addr_t'(a0);
        w_waddr[1] = reg_addr_t'(a1);
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            w_wren[s] = 1'b1;
            w_fwren[s] = 1'b1;
            w_data[s] = $urandom;
            w_fdata[s] = {$urandom, $urandom};
        end
        step();
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            if (w_waddr[s] != 5'd0) begin
                x_model[w_waddr[s]] = w_data[s]; // x0 stays zero.
            end
            f_model[w_waddr[s]] = w_fdata[s];
        end
        idle_inputs();
    endtask

    task automatic reset_state();
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            check_value($sformatf("q_valid[%0d]", s), 64'(q_valid[s]), 64'h0);
        end
        check_value("issue_stall", 64'(issue_stall), 64'h0);
        drive_read(0, 5, 31);
        drive_read(1, 0, 17);
        step();
        check_operands(0, 5, 31);
        check_operands(1, 0, 17);
        idle_inputs();
    endtask

    task automatic register_reads();
        for (int i = 0; i < `REG_COUNT; i += 2) begin
            write_pair(i, i + 1);
        end
        for (int r = 0; r < `REG_COUNT; r += 4) begin
            drive_read(0, r, r + 1);
            drive_read(1, r + 2, r + 3);
            step();
            check_operands(0, r, r + 1);
            check_operands(1, r + 2, r + 3);
        end
        idle_inputs();
    endtask

    // Phase 0 has every source on x9; each later phase drops the youngest.
    task automatic bypass_priority();
        xword_t x_exp;
        fword_t f_exp;
        for (int phase = 0; phase < 4; phase++) begin
            drive_read(0, 9, 9);
            drive_read(1, 9, 9);
            for (int s = 0; s < `ISSUE_WIDTH; s++) begin
                e_valid[s] = 1'b1;
                e_waddr[s] = 5'd9;
                e_result[s] = $urandom;
                e_fresult[s] = {$urandom, $urandom};
            end
            e_wren[1] = (phase == 0);
            e_fwren[1] = (phase == 0);
            e_wren[0] = (phase <= 1);
            e_fwren[0] = (phase <= 1);
            w_waddr[0] = 5'd9;
            w_wren[0] = (phase <= 2);
            w_fwren[0] = (phase <= 2);
            w_data[0] = $urandom;
            w_fdata[0] = {$urandom, $urandom};
            x_exp = (phase == 0) ? e_result[1] : (phase == 1) ? e_result[0] :
                    (phase == 2) ? w_data[0] : x_model[9];
            f_exp = (phase == 0) ? e_fresult[1] : (phase == 1) ? e_fresult[0] :
                    (phase == 2) ? w_fdata[0] : f_model[9];
            step();
            for (int s = 0; s < `ISSUE_WIDTH; s++) begin
                check_value($sformatf("q_rdata1[%0d]", s), 64'(q_rdata1[s]), 64'(x_exp));
                check_value($sformatf("q_rdata2[%0d]", s), 64'(q_rdata2[s]), 64'(x_exp));
                check_value($sformatf("q_frdata1[%0d]", s), q_frdata1[s], f_exp);
                check_value($sformatf("q_frdata2[%0d]", s), q_frdata2[s], f_exp);
            end
            if (phase <= 2) begin
                x_model[9] = w_data[0];
                f_model[9] = w_fdata[0];
            end
            idle_inputs();
        end
    endtask

    task automatic load_use_stall();
        for (int kind = 0; kind < 2; kind++) begin
            drive_read(0, 3, 4);
            drive_read(1, 12, 5);
            e_valid[kind] = 1'b1;
            e_load[kind] = (kind == 0); // Integer load on x12.
            e_fload[kind] = (kind == 1); // FP load on f4.
            e_waddr[kind] = (kind == 0) ? 5'd12 : 5'd4;
            repeat (2) begin
                step();
                check_value("issue_stall", 64'(stall_at_edge), 64'h1);
                check_value("q_valid[0]", 64'(q_valid[0]), 64'h0);
                check_value("q_valid[1]", 64'(q_valid[1]), 64'h0);
            end
            e_valid[kind] = 1'b0;
            e_load[kind] = 1'b0;
            e_fload[kind] = 1'b0;
            wait_accept();
            check_operands(0, 3, 4);
            check_operands(1, 12, 5);
            idle_inputs();
        end
        drive_read(0, 0, 6);
        drive_read(1, 7, 8);
        e_valid[0] = 1'b1;
        e_load[0] = 1'b1;
        e_waddr[0] = 5'd0;
        step();
        check_value("issue_stall", 64'(stall_at_edge), 64'h0);
        check_operands(0, 0, 6);
        check_operands(1, 7, 8);
        idle_inputs();
    endtask

    // FP fields pass with the FPU on and read as zero with it off.
    task automatic fpu_gating();
        logic fp_on;
        for (int pass = 0; pass < 2; pass++) begin
            fp_on = (pass == 0);
            fs = fp_on ? fs_dirty : fs_off;
            for (int s = 0; s < `ISSUE_WIDTH; s++) begin
                drive_read(s, 10 + s, 20 + s);
                d_wren[s] = 1'b1;
                d_fwren[s] = 1'b1;
                d_load[s] = 1'b1;
                d_fload[s] = 1'b1;
                d_fp_op[s] = 1'b1;
            end
            step();
            for (int s = 0; s < `ISSUE_WIDTH; s++) begin
                check_value($sformatf("q_valid[%0d]", s), 64'(q_valid[s]), 64'h1);
                check_value($sformatf("q_wren[%0d]", s), 64'(q_wren[s]), 64'h1);
                check_value($sformatf("q_load[%0d]", s), 64'(q_load[s]), 64'h1);
                check_value($sformatf("q_fwren[%0d]", s), 64'(q_fwren[s]), 64'(fp_on));
                check_value($sformatf("q_fload[%0d]", s), 64'(q_fload[s]), 64'(fp_on));
                check_value($sformatf("q_fp_op[%0d]", s), 64'(q_fp_op[s]), 64'(fp_on));
                check_value($sformatf("q_rdata1[%0d]", s), 64'(q_rdata1[s]),
                            64'(x_model[10 + s]));
                check_value($sformatf("q_rdata2[%0d]", s), 64'(q_rdata2[s]),
                            64'(x_model[20 + s]));
                check_value($sformatf("q_frdata1[%0d]", s), q_frdata1[s],
                            fp_on ? f_model[10 + s] : 64'h0);
                check_value($sformatf("q_frdata2[%0d]", s), q_frdata2[s],
                            fp_on ? f_model[20 + s] : 64'h0);
            end
            idle_inputs();
        end
    endtask

    task automatic backpressure_flush();
        drive_read(0, 13, 14);
        drive_read(1, 15, 16);
        d_pc[0] = 32'h100;
        d_pc[1] = 32'h104;
        step();
        stall_in = 1'b1;
        drive_read(0, 1, 2); // A second pair waits in decode.
        drive_read(1, 3, 5);
        d_pc[0] = 32'h200;
        d_pc[1] = 32'h204;
        repeat (3) begin
            step();
            check_value("issue_stall", 64'(stall_at_edge), 64'h1);
            check_value("q_pc[0]", 64'(q_pc[0]), 64'h100);
            check_value("q_pc[1]", 64'(q_pc[1]), 64'h104);
            check_operands(0, 13, 14);
            check_operands(1, 15, 16);
        end
        flush = 1'b1;
        step();
        check_value("issue_stall", 64'(stall_at_edge), 64'h0);
        check_value("q_valid[0]", 64'(q_valid[0]), 64'h0);
        check_value("q_valid[1]", 64'(q_valid[1]), 64'h0);
        idle_inputs();
    endtask

    initial begin
        void'($urandom(76));
        for (int r = 0; r < `REG_COUNT; r++) begin
            x_model[r] = '0;
            f_model[r] = '0;
        end
        reset = 1'b0;
        idle_inputs();
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        reset_state();
        register_reads();
        bypass_priority();
        load_use_stall();
        fpu_gating();
        backpressure_flush();
        $display("sim passed");
        $finish;
    end

endmodule
